/* design/l1d_pkg.sv */
`default_nettype none

package l1d_pkg;

	// Address layout is tag | set | word | byte
	parameter int ADDR_W     = 32;
	parameter int TAG_W      = 22;
	parameter int SET_W      = 4;
	parameter int WORD_SEL_W = 4;

	parameter int WORD_W     = 32;
	parameter int LINE_WORDS = 16;		// 64-byte line

	parameter int MAX_WAYS   = 4;		// Upper bound for NUM_WAYS

	typedef logic [TAG_W-1:0]             tag_t;
	typedef logic [SET_W-1:0]             set_t;
	typedef logic [WORD_SEL_W-1:0]        word_sel_t;
	typedef logic [$clog2(MAX_WAYS)-1:0]  way_t;
	typedef logic [WORD_W-1:0]            word_t;

	// Word k sits at bits [k*32 +: 32]
	typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

	// What the tag array does this cycle
	typedef enum logic [1:0] {
		TAG_OP_NONE = 2'd0,
		TAG_OP_FILL = 2'd1,		// Write wins over read
		TAG_OP_READ = 2'd2
	} tag_op_e;

endpackage

`default_nettype wire

/* design/l1d_if.sv */
`default_nettype none

// Request fields produced by decode, used by every later stage
interface l1d_lookup_if;
	logic                 rd_accept;
	l1d_pkg::set_t        rd_set;
	l1d_pkg::tag_t        rd_tag;
	l1d_pkg::word_sel_t   rd_word;
	l1d_pkg::tag_op_e     tag_op;
	l1d_pkg::set_t        wr_set;

	modport decode (output rd_accept, rd_set, rd_tag, rd_word, tag_op, wr_set);
	modport tag    (input rd_set, rd_tag, tag_op, wr_set);
	modport data   (input rd_set, wr_set);
	modport result (input rd_accept, rd_word);
endinterface

// Way decisions made by tag control
interface l1d_fill_if;
	logic            fill_en;
	l1d_pkg::way_t   fill_way;
	logic            hit;
	l1d_pkg::way_t   hit_way;

	modport tag    (output fill_en, fill_way, hit, hit_way);
	modport data   (input fill_en, fill_way);
	modport result (input hit, hit_way);
endinterface

`default_nettype wire

/* design/l1d_req_decode.sv */
`default_nettype none

module l1d_req_decode (
	input  wire logic                         iRD_REQ,
	input  wire logic                         iWR_REQ,
	input  wire logic                         iRD_BUSY,
	input  wire logic [l1d_pkg::ADDR_W-1:0]   rd_addr,
	input  wire logic [l1d_pkg::ADDR_W-1:0]   wr_addr,
	output logic                              rd_busy,
	l1d_lookup_if.decode                      lk
);

	localparam int SET_LSB  = l1d_pkg::ADDR_W - l1d_pkg::TAG_W - l1d_pkg::SET_W;
	localparam int WORD_LSB = SET_LSB - l1d_pkg::WORD_SEL_W;

	logic collide;

	assign lk.rd_tag  = rd_addr[l1d_pkg::ADDR_W-1 -: l1d_pkg::TAG_W];
	assign lk.rd_set  = rd_addr[SET_LSB +: l1d_pkg::SET_W];
	assign lk.rd_word = rd_addr[WORD_LSB +: l1d_pkg::WORD_SEL_W];
	assign lk.wr_set  = wr_addr[SET_LSB +: l1d_pkg::SET_W];

	// Read and write to one address in the same cycle
	assign collide = iRD_REQ && iWR_REQ && (rd_addr == wr_addr);

	assign rd_busy      = iRD_BUSY || collide;
	assign lk.rd_accept = iRD_REQ && !rd_busy;

	always_comb begin
		if (iWR_REQ) begin
			lk.tag_op = l1d_pkg::TAG_OP_FILL;
		end
		else if (lk.rd_accept) begin
			lk.tag_op = l1d_pkg::TAG_OP_READ;
		end
		else begin
			lk.tag_op = l1d_pkg::TAG_OP_NONE;
		end
	end

endmodule

`default_nettype wire

/* design/l1d_tag_ctrl.sv */
`default_nettype none

module l1d_tag_ctrl #(
	parameter int NUM_WAYS = 4
) (
	input  wire logic            iCLOCK,
	input  wire logic            inRESET,
	input  wire logic            iREMOVE,
	input  wire l1d_pkg::tag_t   wr_tag,
	l1d_lookup_if.tag            lk,
	l1d_fill_if.tag              fl
);

	localparam int SETS = 2 ** l1d_pkg::SET_W;

	l1d_pkg::tag_t   tag_q   [NUM_WAYS][SETS];
	logic [SETS-1:0] valid_q [NUM_WAYS];

	logic            rd_match;
	l1d_pkg::way_t   rd_way;
	logic            same_tag;
	l1d_pkg::way_t   same_way;
	logic            free_found;
	l1d_pkg::way_t   free_way;
	l1d_pkg::way_t   victim;

	// Lookup, walking down so the lowest way wins
	always_comb begin
		rd_match = 1'b0;
		rd_way   = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (valid_q[w][lk.rd_set] && (tag_q[w][lk.rd_set] == lk.rd_tag)) begin
				rd_match = 1'b1;
				rd_way   = l1d_pkg::way_t'(w);
			end
		end
	end

	// Victim search, a stored tag matches even when the line is invalid
	always_comb begin
		same_tag   = 1'b0;
		same_way   = '0;
		free_found = 1'b0;
		free_way   = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (tag_q[w][lk.wr_set] == wr_tag) begin
				same_tag = 1'b1;
				same_way = l1d_pkg::way_t'(w);
			end
			if (!valid_q[w][lk.wr_set]) begin
				free_found = 1'b1;
				free_way   = l1d_pkg::way_t'(w);
			end
		end
	end

	always_comb begin
		if (same_tag) begin
			victim = same_way;		// Refill in place
		end
		else if (free_found) begin
			victim = free_way;
		end
		else begin
			victim = l1d_pkg::way_t'(NUM_WAYS - 1);		// All valid, evict the last way
		end
	end

	assign fl.hit      = rd_match;
	assign fl.hit_way  = rd_way;
	assign fl.fill_en  = (lk.tag_op == l1d_pkg::TAG_OP_FILL);
	assign fl.fill_way = victim;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_q[w] <= '0;
				for (int s = 0; s < SETS; s++) begin
					tag_q[w][s] <= '0;
				end
			end
		end
		else if (iREMOVE) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_q[w] <= '0;		// Tags stay
			end
		end
		else begin
			case (lk.tag_op)
				l1d_pkg::TAG_OP_FILL: begin
					tag_q[victim][lk.wr_set]   <= wr_tag;
					valid_q[victim][lk.wr_set] <= 1'b1;
				end
				l1d_pkg::TAG_OP_READ: begin
					// Every valid line has equal priority, nothing to promote
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/l1d_data_array.sv */
`default_nettype none

module l1d_data_array #(
	parameter int NUM_WAYS = 4
) (
	input  wire logic             iCLOCK,
	input  wire logic             inRESET,
	input  wire logic             iRD_BUSY,
	input  wire l1d_pkg::line_t   wr_line,
	l1d_lookup_if.data            lk,
	l1d_fill_if.data              fl,
	output l1d_pkg::line_t        way_lines [NUM_WAYS]
);

	localparam int SETS = 2 ** l1d_pkg::SET_W;

	l1d_pkg::line_t mem [NUM_WAYS][SETS];
	l1d_pkg::set_t  rd_set_q;

	// Whole-line fill into the chosen way
	always_ff @(posedge iCLOCK) begin
		if (fl.fill_en) begin
			mem[fl.fill_way][lk.wr_set] <= wr_line;
		end
	end

	// Read index follows the request, frozen under back-pressure
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rd_set_q <= '0;
		end
		else if (!iRD_BUSY) begin
			rd_set_q <= lk.rd_set;
		end
	end

	// Asynchronous read, so a fill at edge N is visible after it
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_lines[w] = mem[w][rd_set_q];
		end
	end

endmodule

`default_nettype wire

/* design/l1d_read_result.sv */
`default_nettype none

module l1d_read_result #(
	parameter int NUM_WAYS = 4
) (
	input  wire logic             iCLOCK,
	input  wire logic             inRESET,
	input  wire logic             iREMOVE,
	input  wire logic             iRD_BUSY,
	input  wire l1d_pkg::line_t   way_lines [NUM_WAYS],
	l1d_lookup_if.result          lk,
	l1d_fill_if.result            fl,
	output logic                  rd_valid,
	output logic                  rd_hit,
	output l1d_pkg::word_t        rd_data
);

	logic                 valid_q;
	logic                 hit_q;
	l1d_pkg::way_t        way_q;
	l1d_pkg::word_sel_t   word_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			hit_q   <= 1'b0;
			way_q   <= '0;
			word_q  <= '0;
		end
		else if (iREMOVE) begin
			valid_q <= 1'b0;		// Drop pending result
			hit_q   <= 1'b0;
		end
		else if (!iRD_BUSY) begin
			valid_q <= lk.rd_accept;
			hit_q   <= fl.hit;
			way_q   <= fl.hit_way;
			word_q  <= lk.rd_word;
		end
	end

	// Result hidden while the consumer stalls
	assign rd_valid = valid_q && !iRD_BUSY;
	assign rd_hit   = rd_valid && hit_q;
	assign rd_data  = rd_hit ? way_lines[way_q][word_q] : '0;

endmodule

`default_nettype wire

/* design/l1d_top.sv */
`default_nettype none

module l1d_top #(
	parameter int NUM_WAYS = 4
) (
	input  wire logic                         iCLOCK,
	input  wire logic                         inRESET,
	input  wire logic                         iREMOVE,
	input  wire logic                         iRD_REQ,
	input  wire logic [l1d_pkg::ADDR_W-1:0]   iRD_ADDR,
	input  wire logic                         iRD_BUSY,
	output logic                              oRD_BUSY,
	output logic                              oRD_VALID,
	output logic                              oRD_HIT,
	output l1d_pkg::word_t                    oRD_DATA,
	input  wire logic                         iWR_REQ,
	input  wire logic [l1d_pkg::ADDR_W-1:0]   iWR_ADDR,
	input  wire l1d_pkg::line_t               iWR_DATA
);

	l1d_lookup_if lk_if ();
	l1d_fill_if   fl_if ();

	l1d_pkg::line_t way_lines [NUM_WAYS];

	l1d_req_decode u_decode (
		.iRD_REQ  (iRD_REQ),
		.iWR_REQ  (iWR_REQ),
		.iRD_BUSY (iRD_BUSY),
		.rd_addr  (iRD_ADDR),
		.wr_addr  (iWR_ADDR),
		.rd_busy  (oRD_BUSY),
		.lk       (lk_if.decode)
	);

	l1d_tag_ctrl #(.NUM_WAYS(NUM_WAYS)) u_tag (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.iREMOVE (iREMOVE),
		.wr_tag  (iWR_ADDR[l1d_pkg::ADDR_W-1 -: l1d_pkg::TAG_W]),		// Write tag field
		.lk      (lk_if.tag),
		.fl      (fl_if.tag)
	);

	l1d_data_array #(.NUM_WAYS(NUM_WAYS)) u_data (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.iRD_BUSY  (iRD_BUSY),
		.wr_line   (iWR_DATA),
		.lk        (lk_if.data),
		.fl        (fl_if.data),
		.way_lines (way_lines)
	);

	l1d_read_result #(.NUM_WAYS(NUM_WAYS)) u_result (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.iREMOVE   (iREMOVE),
		.iRD_BUSY  (iRD_BUSY),
		.way_lines (way_lines),
		.lk        (lk_if.result),
		.fl        (fl_if.result),
		.rd_valid  (oRD_VALID),
		.rd_hit    (oRD_HIT),
		.rd_data   (oRD_DATA)
	);

endmodule

`default_nettype wire

/* include/l1d_tb_tasks.svh */
`ifndef L1D_TB_TASKS_SVH
`define L1D_TB_TASKS_SVH

// Word k of a filled line is base + k
function automatic l1d_pkg::line_t make_line(input l1d_pkg::word_t base);
	l1d_pkg::line_t line;
	for (int k = 0; k < l1d_pkg::LINE_WORDS; k++) begin
		line[k] = base + l1d_pkg::word_t'(k);
	end
	return line;
endfunction

// Pattern word at the address's word select, zero on a miss
function automatic l1d_pkg::word_t expected_word(input logic [l1d_pkg::ADDR_W-1:0] addr,
		input l1d_pkg::word_t base, input logic hit);
	l1d_pkg::word_sel_t sel;
	sel = addr[l1d_pkg::ADDR_W-l1d_pkg::TAG_W-l1d_pkg::SET_W-1 -: l1d_pkg::WORD_SEL_W];
	return hit ? base + l1d_pkg::word_t'(sel) : '0;
endfunction

task automatic flag_cmp(input string name, input logic got, input logic exp);
	checks++;
	test_checks++;
	if (got !== exp) begin
		$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		errors++;
		test_errors++;
	end
endtask

task automatic word_cmp(input string name, input l1d_pkg::word_t got, input l1d_pkg::word_t exp);
	checks++;
	test_checks++;
	if (got !== exp) begin
		$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		errors++;
		test_errors++;
	end
endtask

task automatic report_test(input logic [7:0] num);
	tests_done++;
	$display("test %0d done: %0d checks, %0d mismatches", num, test_checks, test_errors);
	test_checks = 0;		// Per-test counts restart
	test_errors = 0;
endtask

`endif

/* verif/l1d_tb.sv */
`default_nettype none

module l1d_tb;

	localparam logic [3:0] OP_WRITE   = 4'd1;
	localparam logic [3:0] OP_READ    = 4'd2;
	localparam logic [3:0] OP_FLUSH   = 4'd3;
	localparam logic [3:0] OP_COLLIDE = 4'd4;
	localparam logic [3:0] OP_STALL   = 4'd5;
	localparam int MAX_STEPS    = 64;
	localparam int WAIT_LIMIT   = 20;
	localparam int STALL_CYCLES = 4;

	// One row of the data file
	typedef struct packed {
		logic [7:0]                  test;
		logic [3:0]                  op;
		logic [l1d_pkg::ADDR_W-1:0]  addr;
		l1d_pkg::word_t              base;
		logic [3:0]                  hit;
		logic [3:0]                  busy;
	} step_t;

	logic                        iCLOCK;
	logic                        inRESET;
	logic                        remove;
	logic                        rd_req;
	logic [l1d_pkg::ADDR_W-1:0]  rd_addr;
	logic                        rd_stall;
	logic                        rd_busy;
	logic                        rd_valid;
	logic                        rd_hit;
	l1d_pkg::word_t              rd_data;
	logic                        wr_req;
	logic [l1d_pkg::ADDR_W-1:0]  wr_addr;
	l1d_pkg::line_t              wr_data;

	logic [83:0] steps [MAX_STEPS];
	int checks;
	int errors;
	int test_checks;
	int test_errors;
	int tests_done;

	`include "l1d_tb_tasks.svh"

	l1d_top #(.NUM_WAYS(4)) dut_i (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.iREMOVE   (remove),
		.iRD_REQ   (rd_req),
		.iRD_ADDR  (rd_addr),
		.iRD_BUSY  (rd_stall),
		.oRD_BUSY  (rd_busy),
		.oRD_VALID (rd_valid),
		.oRD_HIT   (rd_hit),
		.oRD_DATA  (rd_data),
		.iWR_REQ   (wr_req),
		.iWR_ADDR  (wr_addr),
		.iWR_DATA  (wr_data)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #10 iCLOCK = ~iCLOCK;
	end

	// Returns at a negedge, ok low when oRD_VALID never rose
	task automatic wait_valid(output logic ok);
		int n;
		n = 0;
		@(negedge iCLOCK);
		while (rd_valid !== 1'b1 && n < WAIT_LIMIT) begin
			n++;
			@(negedge iCLOCK);
		end
		ok = (rd_valid === 1'b1);
		if (!ok) begin
			$display("timeout: oRD_VALID did not rise within %0d cycles", WAIT_LIMIT);
			errors++;
			test_errors++;
		end
	endtask

	task automatic verify_read(input step_t st);
		flag_cmp("oRD_HIT", rd_hit, st.hit[0]);
		word_cmp("oRD_DATA", rd_data, expected_word(st.addr, st.base, st.hit[0]));
	endtask

	task automatic write_line(input step_t st);
		@(posedge iCLOCK);
		wr_req  <= 1'b1;
		wr_addr <= st.addr;
		wr_data <= make_line(st.base);
		@(posedge iCLOCK);
		wr_req  <= 1'b0;		// Taken at this edge
	endtask

	// A read accepted at the flush edge is dropped
	task automatic flush_cache(input step_t st);
		@(posedge iCLOCK);
		remove  <= 1'b1;
		rd_req  <= 1'b1;
		rd_addr <= st.addr;
		@(posedge iCLOCK);
		remove <= 1'b0;
		rd_req <= 1'b0;
		@(negedge iCLOCK);
		flag_cmp("oRD_VALID", rd_valid, 1'b0);
	endtask

	// Back to back reads, result of read i checked while read i+1 is issued
	task automatic read_burst(input int first, input int count);
		step_t st;
		logic  ok;
		for (int i = 0; i <= count; i++) begin
			@(posedge iCLOCK);
			if (i < count) begin
				st = steps[first + i];
				rd_req  <= 1'b1;
				rd_addr <= st.addr;
			end
			else begin
				rd_req <= 1'b0;
			end
			if (i > 0) begin
				wait_valid(ok);
				if (ok) begin
					verify_read(steps[first + i - 1]);
				end
			end
			else begin
				@(negedge iCLOCK);
			end
			if (i < count) begin
				flag_cmp("oRD_BUSY", rd_busy, st.busy[0]);
			end
		end
	endtask

	task automatic collide_read_write(input step_t st);
		logic ok;
		@(posedge iCLOCK);
		wr_req  <= 1'b1;
		wr_addr <= st.addr;
		wr_data <= make_line(st.base);
		rd_req  <= 1'b1;
		rd_addr <= st.addr;
		@(negedge iCLOCK);
		flag_cmp("oRD_BUSY", rd_busy, st.busy[0]);
		@(posedge iCLOCK);
		wr_req <= 1'b0;		// Read stays up and repeats
		@(negedge iCLOCK);
		flag_cmp("oRD_VALID", rd_valid, 1'b0);
		flag_cmp("oRD_BUSY", rd_busy, 1'b0);
		@(posedge iCLOCK);
		rd_req <= 1'b0;
		wait_valid(ok);
		if (ok) begin
			verify_read(st);
		end
	endtask

	task automatic read_under_stall(input step_t st);
		logic ok;
		@(posedge iCLOCK);
		rd_req  <= 1'b1;
		rd_addr <= st.addr;
		@(posedge iCLOCK);
		rd_req   <= 1'b0;
		rd_stall <= 1'b1;
		repeat (STALL_CYCLES) begin
			@(negedge iCLOCK);
			flag_cmp("oRD_VALID", rd_valid, 1'b0);
			flag_cmp("oRD_HIT", rd_hit, 1'b0);
			word_cmp("oRD_DATA", rd_data, '0);
			flag_cmp("oRD_BUSY", rd_busy, st.busy[0]);
		end
		@(posedge iCLOCK);
		rd_stall <= 1'b0;
		wait_valid(ok);
		if (ok) begin
			verify_read(st);
		end
	endtask

	initial begin
		step_t      st;
		step_t      nxt;
		int         idx;
		int         run;
		logic [7:0] cur_test;
		inRESET  = 1'b0;
		remove   = 1'b0;
		rd_req   = 1'b0;
		rd_addr  = '0;
		rd_stall = 1'b0;
		wr_req   = 1'b0;
		wr_addr  = '0;
		wr_data  = '0;
		checks      = 0;
		errors      = 0;
		test_checks = 0;
		test_errors = 0;
		tests_done  = 0;
		for (int i = 0; i < MAX_STEPS; i++) begin
			steps[i] = '0;		// Op 0 ends the list
		end
		$readmemh("verif/l1d_testdata.txt", steps);
		repeat (16) @(posedge iCLOCK);
		inRESET <= 1'b1;
		idx = 0;
		st  = steps[0];
		cur_test = st.test;
		if (st.op == 4'd0) begin
			$display("no test steps were read from verif/l1d_testdata.txt");
			errors++;
		end
		while (idx < MAX_STEPS && st.op != 4'd0) begin
			if (st.test != cur_test) begin
				report_test(cur_test);
				cur_test = st.test;
			end
			case (st.op)
				OP_WRITE:   write_line(st);
				OP_FLUSH:   flush_cache(st);
				OP_COLLIDE: collide_read_write(st);
				OP_STALL:   read_under_stall(st);
				OP_READ: begin
					run = 1;		// Group a run of reads of one test
					while (idx + run < MAX_STEPS) begin
						nxt = steps[idx + run];
						if (nxt.op != OP_READ || nxt.test != st.test) break;
						run++;
					end
					read_burst(idx, run);
				end
				default: begin
					$display("unknown operation %0d in data file row %0d", st.op, idx);
					errors++;
				end
			endcase
			idx = (st.op == OP_READ) ? idx + run : idx + 1;
			st  = (idx < MAX_STEPS) ? step_t'(steps[idx]) : step_t'('0);
		end
		report_test(cur_test);
		$display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end
		else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/l1d_testdata.txt */
// test _ op _ address _ line base _ expected hit _ expected oRD_BUSY
// op 1 write, 2 read, 3 flush, 4 collide (write and read), 5 read under stall
01_2_00001044_00000000_0_0
01_2_12345678_00000000_0_0
02_1_00002080_A0000000_0_0
02_2_00002080_A0000000_1_0
02_2_00002084_A0000000_1_0
02_2_000020BC_A0000000_1_0
02_2_000020A8_A0000000_1_0
02_2_00002480_00000000_0_0
03_1_00004140_11000000_0_0
03_1_00004540_12000000_0_0
03_1_00004940_13000000_0_0
03_1_00004D40_14000000_0_0
03_1_00005140_15000000_0_0
03_2_00004148_11000000_1_0
03_2_0000454C_12000000_1_0
03_2_00004950_13000000_1_0
03_2_00004D44_00000000_0_0
03_2_0000517C_15000000_1_0
03_1_00004540_22000000_0_0
03_2_0000454C_22000000_1_0
03_2_00004144_11000000_1_0
03_2_00004D40_00000000_0_0
04_3_00000000_00000000_0_0
04_2_00002080_00000000_0_0
04_2_00004148_00000000_0_0
04_2_0000517C_00000000_0_0
04_1_00004940_33000000_0_0
04_2_00004958_33000000_1_0
04_2_00004544_00000000_0_0
04_2_00004140_00000000_0_0
05_4_0000330C_55000000_1_1
06_1_00007780_66000000_0_0
06_5_000077A4_66000000_1_1
06_5_00007B80_00000000_0_1
06_2_000077BC_66000000_1_0

/* flist.f */
+incdir+include
design/l1d_pkg.sv
design/l1d_if.sv
design/l1d_req_decode.sv
design/l1d_tag_ctrl.sv
design/l1d_data_array.sv
design/l1d_read_result.sv
design/l1d_top.sv
verif/l1d_tb.sv
